/* common/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path and register width
`define CPU_XLEN 32

// Instruction and data memory address width
`define CPU_AW 12

// General register count
`define CPU_NREGS 32

// Register index width, low bits of the 12-bit index fields
`define CPU_RIW 5

`endif

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

        typedef enum logic [3:0] {
                NOP = 4'd0,
                LD  = 4'd1,
                STR = 4'd2,
                BRA = 4'd3,
                XOR = 4'd4,
                ADD = 4'd5,
                ROT = 4'd6,
                SHF = 4'd7,
                HLT = 4'd8,
                CMP = 4'd9
        } opcode_e;

        typedef enum logic [2:0] {
                IDLE,
                FETCH,
                DECODE,
                EXECUTE,
                MEM,
                WB
        } state_e;

        typedef enum logic [2:0] {
                ALWAYS  = 3'd0,
                PARITY  = 3'd1,
                EVEN    = 3'd2,
                CARRY   = 3'd3,
                NEG     = 3'd4,
                ZERO    = 3'd5,
                NOCARRY = 3'd6,
                POS     = 3'd7
        } cond_e;

        typedef struct packed {
                opcode_e     opcode;
                logic        imm;           // op1 from src field
                logic        zop2;          // op2 forced to zero
                logic [1:0]  spare;
                logic [11:0] src;           // Bit 11 is shift direction
                logic [11:0] dst;
        } op_fmt_t;

        typedef struct packed {
                opcode_e     opcode;
                logic        spare;
                cond_e       cond;
                logic [11:0] unused;
                logic [11:0] target;
        } br_fmt_t;

        typedef union packed {
                op_fmt_t op;
                br_fmt_t br;
        } instr_u;

endpackage

`default_nettype wire

/* common/alu_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

interface alu_if;
        cpu_pkg::opcode_e       op;
        logic [`CPU_XLEN-1:0]   a;
        logic [`CPU_XLEN-1:0]   b;
        logic                   left;           // Shift and rotate direction
        logic [`CPU_XLEN-1:0]   res;
        logic                   cout;

        modport ctl (
                output op, a, b, left,
                input  res, cout
        );

        modport unit (
                input  op, a, b, left,
                output res, cout
        );
endinterface

`default_nettype wire

/* common/rf_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

interface rf_if;
        logic [`CPU_RIW-1:0]    ra_idx;
        logic [`CPU_RIW-1:0]    rb_idx;
        logic                   we;
        logic [`CPU_RIW-1:0]    wa_idx;
        logic [`CPU_XLEN-1:0]   wd;
        logic [`CPU_XLEN-1:0]   ra_data;
        logic [`CPU_XLEN-1:0]   rb_data;

        modport ctl (
                output ra_idx, rb_idx, we, wa_idx, wd,
                input  ra_data, rb_data
        );

        modport mem (
                input  ra_idx, rb_idx, we, wa_idx, wd,
                output ra_data, rb_data
        );
endinterface

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module regfile (
        input  logic    clk,
        input  logic    rstn,
        rf_if.mem       rf
);
        logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

        always_ff @(posedge clk) begin
                if (!rstn) begin
                        for (int i = 0; i < `CPU_NREGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (rf.we) begin
                        regs[rf.wa_idx] <= rf.wd;
                end
        end

        // Operand reads are asynchronous
        assign rf.ra_data = regs[rf.ra_idx];
        assign rf.rb_data = regs[rf.rb_idx];

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module alu (
        alu_if.unit     alu
);
        localparam int SW = $clog2(`CPU_XLEN);

        logic [SW-1:0]            amt;
        logic [2*`CPU_XLEN-1:0]   rot_l;
        logic [2*`CPU_XLEN-1:0]   rot_r;

        assign amt = alu.a[SW-1:0];                     // Count modulo word width

        // Doubled word makes the wrap-around fall out of a plain shift
        assign rot_l = {alu.b, alu.b} << amt;
        assign rot_r = {alu.b, alu.b} >> amt;

        always_comb begin
                alu.res  = '0;
                alu.cout = 1'b0;
                case (alu.op)
                        cpu_pkg::XOR: begin
                                alu.res = alu.a ^ alu.b;
                        end
                        cpu_pkg::ADD: begin
                                {alu.cout, alu.res} = alu.a + alu.b;
                        end
                        cpu_pkg::ROT: begin
                                if (alu.left) begin
                                        alu.res = rot_l[2*`CPU_XLEN-1:`CPU_XLEN];
                                end else begin
                                        alu.res = rot_r[`CPU_XLEN-1:0];
                                end
                        end
                        cpu_pkg::SHF: begin
                                if (alu.left) begin
                                        alu.res = alu.b << amt;
                                end else begin
                                        alu.res = alu.b >> amt;  // Logical
                                end
                        end
                        cpu_pkg::CMP: begin
                                alu.res = ~alu.a;
                        end
                        default: begin
                        end
                endcase
        end

endmodule

`default_nettype wire

/* logic/psr.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module psr (
        input  logic                    clk,
        input  logic                    rstn,
        input  logic                    flag_we,
        input  logic [`CPU_XLEN-1:0]    res,
        input  logic                    cin,
        input  cpu_pkg::cond_e          cond,
        output logic                    take
);
        logic c_flag;
        logic p_flag;
        logic e_flag;
        logic n_flag;
        logic z_flag;

        always_ff @(posedge clk) begin
                if (!rstn) begin
                        c_flag <= 1'b0;
                        p_flag <= 1'b0;
                        e_flag <= 1'b0;
                        n_flag <= 1'b0;
                        z_flag <= 1'b0;
                end else if (flag_we) begin
                        c_flag <= cin;
                        p_flag <= ^res;
                        e_flag <= ~res[0];
                        n_flag <= res[`CPU_XLEN-1];
                        z_flag <= (res == '0);
                end
        end

        always_comb begin
                case (cond)
                        cpu_pkg::ALWAYS:  take = 1'b1;
                        cpu_pkg::PARITY:  take = p_flag;
                        cpu_pkg::EVEN:    take = e_flag;
                        cpu_pkg::CARRY:   take = c_flag;
                        cpu_pkg::NEG:     take = n_flag;
                        cpu_pkg::ZERO:    take = z_flag;
                        cpu_pkg::NOCARRY: take = ~c_flag;
                        default:          take = ~n_flag;  // POS
                endcase
        end

endmodule

`default_nettype wire

/* logic/sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module sequencer (
        input  logic                    clk,
        input  logic                    rstn,
        input  logic [`CPU_XLEN-1:0]    instr_mem,
        input  logic [`CPU_XLEN-1:0]    data_ld,
        output logic [`CPU_AW-1:0]      instr_adrs,
        output logic                    mem_read_instr,
        output logic [`CPU_AW-1:0]      ld_adrs,
        output logic                    mem_ld_en,
        output logic [`CPU_AW-1:0]      str_adrs,
        output logic [`CPU_XLEN-1:0]    data_str,
        output logic                    mem_str_en,
        output logic [`CPU_XLEN-1:0]    result,
        output logic                    carry,
        alu_if.ctl                      alu,
        rf_if.ctl                       rf,
        output logic                    flag_we,
        output cpu_pkg::cond_e          cond,
        input  logic                    take
);
        cpu_pkg::state_e        state;
        cpu_pkg::instr_u        ir;
        logic [`CPU_AW-1:0]     pc;
        logic [`CPU_XLEN-1:0]   op1;
        logic [`CPU_XLEN-1:0]   op2;
        logic                   halt;
        logic                   is_alu;
        logic [`CPU_XLEN-1:0]   imm_val;

        assign imm_val    = `CPU_XLEN'(ir.op.src);     // Zero-extended src field
        assign instr_adrs = pc;

        always_comb begin
                case (ir.op.opcode)
                        cpu_pkg::XOR, cpu_pkg::ADD, cpu_pkg::ROT,
                        cpu_pkg::SHF, cpu_pkg::CMP: is_alu = 1'b1;
                        default:                    is_alu = 1'b0;
                endcase
        end

        // Only the low index bits select a register
        assign rf.ra_idx = ir.op.src[`CPU_RIW-1:0];
        assign rf.rb_idx = ir.op.dst[`CPU_RIW-1:0];
        assign rf.wa_idx = ir.op.dst[`CPU_RIW-1:0];
        assign rf.we     = (state == cpu_pkg::WB) &&
                           (is_alu || ir.op.opcode == cpu_pkg::LD);

        always_comb begin
                if (ir.op.opcode != cpu_pkg::LD) begin
                        rf.wd = result;
                end else if (ir.op.imm) begin
                        rf.wd = imm_val;
                end else begin
                        rf.wd = data_ld;                // Valid in WB
                end
        end

        assign alu.op   = ir.op.opcode;
        assign alu.a    = op1;
        assign alu.b    = op2;
        assign alu.left = ir.op.src[11];
        assign flag_we  = (state == cpu_pkg::EXECUTE) && is_alu;
        assign cond     = ir.br.cond;

        always_ff @(posedge clk) begin
                if (!rstn) begin
                        state          <= cpu_pkg::IDLE;
                        pc             <= '0;
                        halt           <= 1'b0;
                        mem_read_instr <= 1'b0;
                        mem_ld_en      <= 1'b0;
                        mem_str_en     <= 1'b0;
                        result         <= '0;
                        carry          <= 1'b0;
                end else begin
                        mem_ld_en  <= 1'b0;
                        mem_str_en <= 1'b0;
                        case (state)
                                cpu_pkg::IDLE: begin
                                        // First pass after reset only arms the fetch
                                        if (!halt && mem_read_instr) begin
                                                state          <= cpu_pkg::FETCH;
                                                mem_read_instr <= 1'b0;
                                        end else if (!halt) begin
                                                mem_read_instr <= 1'b1;
                                        end
                                end
                                cpu_pkg::FETCH:  state <= cpu_pkg::DECODE;
                                cpu_pkg::DECODE: state <= cpu_pkg::EXECUTE;
                                cpu_pkg::EXECUTE: begin
                                        state <= cpu_pkg::MEM;
                                        if (is_alu) begin
                                                result <= alu.res;
                                                carry  <= alu.cout;
                                        end
                                        case (ir.op.opcode)
                                                cpu_pkg::LD:  mem_ld_en <= ~ir.op.imm;
                                                cpu_pkg::STR: mem_str_en <= 1'b1;
                                                cpu_pkg::BRA: pc <= take ? ir.br.target : pc + 1'b1;
                                                cpu_pkg::HLT: halt <= 1'b1;
                                                default: begin
                                                end
                                        endcase
                                end
                                cpu_pkg::MEM: state <= cpu_pkg::WB;
                                cpu_pkg::WB: begin
                                        state          <= cpu_pkg::IDLE;
                                        mem_read_instr <= ~halt;  // Next fetch in IDLE
                                        if (ir.op.opcode != cpu_pkg::BRA) begin
                                                pc <= pc + 1'b1;
                                        end
                                end
                                default: state <= cpu_pkg::IDLE;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (state == cpu_pkg::FETCH) begin
                        ir <= instr_mem;
                end
                if (state == cpu_pkg::DECODE) begin
                        op1 <= ir.op.imm  ? imm_val : rf.ra_data;
                        op2 <= ir.op.zop2 ? '0      : rf.rb_data;
                end
                if (state == cpu_pkg::EXECUTE) begin
                        ld_adrs  <= ir.op.src;
                        str_adrs <= ir.op.dst;
                        data_str <= op1;                // Immediate or register src
                end
        end

endmodule

`default_nettype wire

/* logic/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_top (
        input  logic                    clk,
        input  logic                    rstn,
        input  logic [`CPU_XLEN-1:0]    instr_mem,
        input  logic [`CPU_XLEN-1:0]    data_ld,
        output logic [`CPU_AW-1:0]      instr_adrs,
        output logic [`CPU_AW-1:0]      ld_adrs,
        output logic [`CPU_AW-1:0]      str_adrs,
        output logic                    mem_read_instr,
        output logic                    mem_ld_en,
        output logic                    mem_str_en,
        output logic [`CPU_XLEN-1:0]    data_str,
        output logic [`CPU_XLEN-1:0]    result,
        output logic                    carry
);
        logic                   flag_we;
        cpu_pkg::cond_e         cond;
        logic                   take;

        alu_if alu_bus ();
        rf_if  rf_bus ();

        sequencer i_sequencer (
                .clk            (clk),
                .rstn           (rstn),
                .instr_mem      (instr_mem),
                .data_ld        (data_ld),
                .instr_adrs     (instr_adrs),
                .mem_read_instr (mem_read_instr),
                .ld_adrs        (ld_adrs),
                .mem_ld_en      (mem_ld_en),
                .str_adrs       (str_adrs),
                .data_str       (data_str),
                .mem_str_en     (mem_str_en),
                .result         (result),
                .carry          (carry),
                .alu            (alu_bus.ctl),
                .rf             (rf_bus.ctl),
                .flag_we        (flag_we),
                .cond           (cond),
                .take           (take)
        );

        regfile i_regfile (
                .clk    (clk),
                .rstn   (rstn),
                .rf     (rf_bus.mem)
        );

        alu i_alu (
                .alu    (alu_bus.unit)
        );

        // Flags follow the live ALU output in EXECUTE
        psr i_psr (
                .clk     (clk),
                .rstn    (rstn),
                .flag_we (flag_we),
                .res     (alu_bus.res),
                .cin     (alu_bus.cout),
                .cond    (cond),
                .take    (take)
        );

endmodule

`default_nettype wire

/* tests/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
        output logic    clk,
        output logic    rstn
);
        localparam int RST_CYCLES = 16;

        initial begin
                clk = 1'b0;
        end

        always #5 clk = ~clk;                           // 10 ns period

        initial begin
                rstn <= 1'b0;
                repeat (RST_CYCLES) @(posedge clk);
                rstn <= 1'b1;
        end

endmodule

`default_nettype wire

/* tests/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module tb_cpu;
        localparam int MEM_WORDS = 64;

        logic                   clk;
        logic                   rstn;
        logic [`CPU_XLEN-1:0]   instr_mem;
        logic [`CPU_XLEN-1:0]   data_ld;
        logic [`CPU_AW-1:0]     instr_adrs;
        logic [`CPU_AW-1:0]     ld_adrs;
        logic [`CPU_AW-1:0]     str_adrs;
        logic                   mem_read_instr;
        logic                   mem_ld_en;
        logic                   mem_str_en;
        logic [`CPU_XLEN-1:0]   data_str;
        logic [`CPU_XLEN-1:0]   result;
        logic                   carry;

        logic [`CPU_XLEN-1:0]   rom [MEM_WORDS];
        logic [`CPU_XLEN-1:0]   dmem [MEM_WORDS];

        // Reference model state
        logic [`CPU_XLEN-1:0]   m_regs [`CPU_NREGS];
        logic [`CPU_XLEN-1:0]   m_dmem [MEM_WORDS];
        logic [`CPU_AW-1:0]     m_pc = '0;
        logic [`CPU_XLEN-1:0]   m_result = '0;
        logic                   m_carry = 1'b0;
        logic                   m_halted = 1'b0;
        logic [4:0]             flags = '0;             // Carry, parity, even, neg, zero
        logic                   exp_store = 1'b0;
        logic                   exp_load = 1'b0;
        logic [`CPU_AW-1:0]     exp_sadr;
        logic [`CPU_AW-1:0]     exp_ladr;
        logic [`CPU_XLEN-1:0]   exp_sdat;

        int                     n_checks = 0;
        int                     n_errors = 0;
        int                     cyc = 0;
        int                     since_fetch = 100;
        int                     gap = 0;
        int                     n_fetch = 0;
        int                     wp = 0;
        integer                 seed;
        logic                   rstn_q = 1'b0;

        tb_clkgen i_clkgen (
                .clk    (clk),
                .rstn   (rstn)
        );

        cpu_top i_cpu_top (
                .clk            (clk),
                .rstn           (rstn),
                .instr_mem      (instr_mem),
                .data_ld        (data_ld),
                .instr_adrs     (instr_adrs),
                .ld_adrs        (ld_adrs),
                .str_adrs       (str_adrs),
                .mem_read_instr (mem_read_instr),
                .mem_ld_en      (mem_ld_en),
                .mem_str_en     (mem_str_en),
                .data_str       (data_str),
                .result         (result),
                .carry          (carry)
        );

        // Both memories answer one cycle after the strobe
        always @(posedge clk) begin
                if (mem_read_instr) begin
                        instr_mem <= rom[instr_adrs[5:0]];
                end
                if (mem_ld_en) begin
                        data_ld <= dmem[ld_adrs[5:0]];
                end
                if (mem_str_en) begin
                        dmem[str_adrs[5:0]] <= data_str;
                end
        end

        task automatic check_val(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
                n_checks++;
                assert (act_v === exp_v) else begin
                        n_errors++;
                        $display("FAILED t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
                end
        endtask

        task automatic report_error(input string msg);
                n_errors++;
                $display("ERROR t=%0t %s", $time, msg);
        endtask

        function automatic logic [31:0] op_word(input logic [3:0] opc, input logic imm,
                                                input logic zop2, input logic [11:0] src,
                                                input logic [11:0] dst);
                return {opc, imm, zop2, 2'b00, src, dst};
        endfunction

        function automatic logic [31:0] br_word(input logic [2:0] cond, input logic [11:0] tgt);
                return {cpu_pkg::BRA, 1'b0, cond, 12'd0, tgt};
        endfunction

        task automatic emit(input logic [31:0] w);
                rom[wp] = w;
                wp++;
        endtask

        task automatic emit_branch(input logic [2:0] cond);
                emit(br_word(cond, 12'(wp + 2)));       // Taken skips the NOP
                emit(32'd0);
        endtask

        function automatic logic cond_met(input logic [2:0] cond);
                case (cond)
                        cpu_pkg::ALWAYS:  return 1'b1;
                        cpu_pkg::CARRY:   return flags[4];
                        cpu_pkg::PARITY:  return flags[3];
                        cpu_pkg::EVEN:    return flags[2];
                        cpu_pkg::NEG:     return flags[1];
                        cpu_pkg::ZERO:    return flags[0];
                        cpu_pkg::NOCARRY: return !flags[4];
                        default:          return !flags[1];
                endcase
        endfunction

        task automatic model_step(input logic [31:0] w);
                logic [3:0]  opc;
                logic [11:0] src;
                logic [11:0] dst;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] r;
                logic        c;
                logic        alu_op;
                int          n;
                opc    = w[31:28];
                src    = w[23:12];
                dst    = w[11:0];
                a      = w[27] ? {20'd0, src} : m_regs[src[4:0]];
                b      = w[26] ? '0 : m_regs[dst[4:0]];
                n      = int'(a[4:0]);
                r      = '0;
                c      = 1'b0;
                alu_op = 1'b1;
                exp_store = 1'b0;
                exp_load  = 1'b0;
                m_pc      = m_pc + 1'b1;
                case (opc)
                        cpu_pkg::XOR: r = a ^ b;
                        cpu_pkg::ADD: {c, r} = {1'b0, a} + {1'b0, b};
                        cpu_pkg::SHF: r = src[11] ? (b << n) : (b >> n);
                        cpu_pkg::ROT: r = src[11] ? ((b << n) | (b >> (32 - n)))
                                                  : ((b >> n) | (b << (32 - n)));
                        cpu_pkg::CMP: r = ~a;
                        default:      alu_op = 1'b0;
                endcase
                if (alu_op) begin
                        m_result         = r;
                        m_carry          = c;
                        m_regs[dst[4:0]] = r;
                        flags            = {c, ^r, ~r[0], r[31], r == 0};
                end
                case (opc)
                        cpu_pkg::LD: begin
                                if (w[27]) begin
                                        m_regs[dst[4:0]] = a;
                                end else begin
                                        exp_load         = 1'b1;
                                        exp_ladr         = src;
                                        m_regs[dst[4:0]] = m_dmem[src[5:0]];
                                end
                        end
                        cpu_pkg::STR: begin
                                exp_store        = 1'b1;
                                exp_sadr         = dst;
                                exp_sdat         = a;
                                m_dmem[dst[5:0]] = a;
                        end
                        cpu_pkg::BRA: begin
                                if (cond_met(w[26:24])) begin
                                        m_pc = w[11:0];
                                end
                        end
                        cpu_pkg::HLT: m_halted = 1'b1;
                        default: begin
                        end
                endcase
        endtask

        task automatic load_program();
                for (int i = 0; i < MEM_WORDS; i++) begin
                        rom[i] = {cpu_pkg::HLT, 22'd0, 6'(i)};
                end
                emit(op_word(cpu_pkg::LD,  1, 0, 12'h5a3, 12'd1));
                emit(op_word(cpu_pkg::LD,  1, 0, 12'h0ff, 12'd2));
                emit(op_word(cpu_pkg::STR, 1, 0, 12'h123, 12'd40));
                emit(op_word(cpu_pkg::STR, 0, 0, 12'd1,   12'd41));
                emit(op_word(cpu_pkg::XOR, 0, 0, 12'd1,   12'd2));
                emit(op_word(cpu_pkg::ADD, 0, 0, 12'd1,   12'd2));
                emit(op_word(cpu_pkg::STR, 0, 0, 12'd2,   12'd42));
                emit(op_word(cpu_pkg::LD,  1, 0, 12'habc, 12'd5));
                emit(op_word(cpu_pkg::SHF, 1, 0, 12'h804, 12'd1));     // Left by 4
                emit(op_word(cpu_pkg::SHF, 1, 0, 12'h003, 12'd1));     // Right by 3
                emit(op_word(cpu_pkg::ROT, 1, 0, 12'h81c, 12'd5));     // Left by 28
                emit(op_word(cpu_pkg::ROT, 1, 0, 12'h005, 12'd5));
                emit(op_word(cpu_pkg::STR, 0, 0, 12'd1,   12'd43));
                emit(op_word(cpu_pkg::STR, 0, 0, 12'd5,   12'd44));
                emit(op_word(cpu_pkg::LD,  0, 0, 12'd7,   12'd7));     // Random data word
                emit(op_word(cpu_pkg::STR, 0, 0, 12'd7,   12'd45));
                emit(op_word(cpu_pkg::CMP, 1, 0, 12'd0,   12'd4));     // All ones, negative
                for (int c = 0; c < 8; c++) begin
                        emit_branch(3'(c));
                end
                emit(op_word(cpu_pkg::ADD, 1, 0, 12'd1,   12'd4));     // Zero with carry
                for (int c = 0; c < 8; c++) begin
                        emit_branch(3'(c));
                end
                emit(op_word(cpu_pkg::STR, 0, 0, 12'd4,   12'd46));
                emit(op_word(cpu_pkg::CMP, 0, 0, 12'd2,   12'd9));
                emit(op_word(cpu_pkg::STR, 0, 0, 12'd9,   12'd47));
                emit(op_word(cpu_pkg::XOR, 1, 1, 12'd1,   12'd8));     // Odd parity
                emit_branch(cpu_pkg::PARITY);
                emit({cpu_pkg::HLT, 28'd0});
        endtask

        always @(posedge clk) begin
                cyc++;
                gap++;
                if (since_fetch < 100) begin
                        since_fetch++;
                end
                if (cyc > 1 && (!rstn || !rstn_q)) begin
                        check_val("mem_read_instr", 0, mem_read_instr);
                        check_val("mem_ld_en", 0, mem_ld_en);
                        check_val("mem_str_en", 0, mem_str_en);
                end
                if (since_fetch == 4) begin             // MEM cycle of the instruction
                        check_val("result", m_result, result);
                        check_val("carry", m_carry, carry);
                        check_val("mem_str_en", exp_store, mem_str_en);
                        check_val("mem_ld_en", exp_load, mem_ld_en);
                        if (exp_store) begin
                                check_val("str_adrs", exp_sadr, str_adrs);
                                check_val("data_str", exp_sdat, data_str);
                        end
                        if (exp_load) begin
                                check_val("ld_adrs", exp_ladr, ld_adrs);
                        end
                end else if (cyc > 1 && rstn_q) begin
                        assert (!mem_str_en) else report_error("store pulse outside MEM cycle");
                        assert (!mem_ld_en) else report_error("load pulse outside MEM cycle");
                end
                if (rstn && mem_read_instr) begin
                        assert (!m_halted) else report_error("instruction fetch after HLT");
                        check_val("instr_adrs", m_pc, instr_adrs);
                        if (n_fetch > 0) begin
                                check_val("fetch interval", 6, gap);
                        end
                        model_step(rom[m_pc[5:0]]);
                        n_fetch++;
                        since_fetch = 0;
                        gap         = 0;
                end
                rstn_q = rstn;
        end

        initial begin
                int wait_cyc;
                instr_mem <= '0;
                data_ld   <= '0;
                seed      = 44458;
                for (int i = 0; i < `CPU_NREGS; i++) begin
                        m_regs[i] = '0;
                end
                for (int i = 0; i < MEM_WORDS; i++) begin
                        m_dmem[i] = $random(seed);
                        dmem[i]   <= m_dmem[i];
                end
                load_program();
                wait_cyc = 0;
                while (!rstn && wait_cyc < 100) begin
                        @(negedge clk);
                        wait_cyc++;
                end
                if (!rstn) begin
                        report_error("timeout, reset was never released");
                end else begin
                        wait_cyc = 0;
                        while (!m_halted && wait_cyc < 2000) begin
                                @(negedge clk);
                                wait_cyc++;
                        end
                        if (!m_halted) begin
                                report_error("timeout, program never reached HLT");
                        end else begin
                                repeat (50) @(negedge clk);     // Quiet window after HLT
                        end
                end
                $display("Run done after %0d fetches: %0d checks, %0d errors",
                         n_fetch, n_checks, n_errors);
                if (n_errors == 0) begin
                        $display("TEST OK");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/cpu_pkg.sv
common/alu_if.sv
common/rf_if.sv
logic/regfile.sv
logic/alu.sv
logic/psr.sv
logic/sequencer.sv
logic/cpu_top.sv
tests/tb_clkgen.sv
tests/tb_cpu.sv

/* Makefile */
SRCS := $(shell grep -v '^+' all.f) common/cpu_macros.svh

run: obj_dir/Vtb_cpu
	@out=$$(./obj_dir/Vtb_cpu); echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

obj_dir/Vtb_cpu: all.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_cpu -f all.f

clean:
	rm -rf obj_dir

.PHONY: run clean
